//--- build.f
design/rv_pkg.sv
design/dx_if.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_hazard.sv
design/rv_execute.sv
design/rv_core.sv
dv/imem_model.sv
dv/rv_core_checker.sv
dv/rv_core_tb.sv

//--- design/dx_if.sv
/* decode to execute bundle with decode and execute modports */
`timescale 1ns/100ps

interface dx_if;
    import rv_pkg::*;

    logic     valid;
    alu_op_e  alu_op;
    word_t    op_a;
    word_t    op_b;
    reg_idx_t rd;

    // execute always accepts, no ready
    modport decode (
        output valid,
        output alu_op,
        output op_a,
        output op_b,
        output rd
    );

    modport execute (
        input valid,
        input alu_op,
        input op_a,
        input op_b,
        input rd
    );

endinterface

//--- design/rv_core.sv
/* RV32I ALU core top: fetch, decode, hazard and execute stages */
`timescale 1ns/100ps

module rv_core #(
    parameter rv_pkg::word_t boot_addr = '0
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             instr_gnt,
    input  rv_pkg::word_t    instr_data,
    output logic             instr_req,
    output rv_pkg::word_t    instr_addr,
    output logic             retire_valid,
    output rv_pkg::reg_idx_t retire_rd,
    output rv_pkg::word_t    retire_data
);
    import rv_pkg::*;

    logic     fetch_valid;
    word_t    fetch_instr;

    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     uses_rs2;
    logic     fwd_a;
    logic     fwd_b;

    logic     wb_en;
    reg_idx_t wb_rd;
    word_t    wb_data;

    dx_if dx ();

    rv_fetch #(
        .boot_addr (boot_addr)
    ) u_fetch (
        .clk         (clk),
        .rst         (rst),
        .instr_gnt   (instr_gnt),
        .instr_data  (instr_data),
        .instr_req   (instr_req),
        .instr_addr  (instr_addr),
        .fetch_valid (fetch_valid),
        .fetch_instr (fetch_instr)
    );

    rv_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_instr (fetch_instr),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .rs1         (rs1),
        .rs2         (rs2),
        .uses_rs2    (uses_rs2),
        .dx          (dx.decode)
    );

    // execute-side destination comes from the write-back port
    rv_hazard u_hazard (
        .rs1      (rs1),
        .rs2      (rs2),
        .ex_rd    (wb_rd),
        .ex_valid (wb_en),
        .uses_rs2 (uses_rs2),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b)
    );

    rv_execute u_execute (
        .clk          (clk),
        .rst          (rst),
        .dx           (dx.execute),
        .wb_en        (wb_en),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

endmodule

//--- design/rv_decode.sv
/* decode stage: opcode and funct decode, 32-entry register file,
   operand selection with forwarding, registered output to execute */
`timescale 1ns/100ps

module rv_decode (
    input  logic             clk,
    input  logic             rst,
    input  logic             fetch_valid,
    input  rv_pkg::word_t    fetch_instr,
    input  logic             fwd_a,
    input  logic             fwd_b,
    input  logic             wb_en,
    input  rv_pkg::reg_idx_t wb_rd,
    input  rv_pkg::word_t    wb_data,
    output rv_pkg::reg_idx_t rs1,
    output rv_pkg::reg_idx_t rs2,
    output logic             uses_rs2,
    dx_if.decode             dx
);
    import rv_pkg::*;

    word_t      regs [32];

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    alu_op_e    alu_op;
    logic       legal;

    word_t      rs1_val;
    word_t      rs2_val;
    word_t      op_a;
    word_t      op_b;

    assign opcode = opcode_e'(fetch_instr[6:0]);
    assign funct3 = instr_funct3(fetch_instr);
    assign funct7 = instr_funct7(fetch_instr);
    assign rs1    = instr_rs1(fetch_instr);
    assign rs2    = instr_rs2(fetch_instr);

    always_comb begin
        legal    = 1'b0;
        uses_rs2 = 1'b0;

        case (funct3)
            3'b000:  alu_op = alu_add;
            3'b001:  alu_op = alu_sll;
            3'b010:  alu_op = alu_slt;
            3'b100:  alu_op = alu_xor;
            3'b101:  alu_op = alu_srl;
            3'b110:  alu_op = alu_or;
            3'b111:  alu_op = alu_and;
            // sltu is not supported
            default: alu_op = alu_add;
        endcase

        case (opcode)
            op_reg: begin
                uses_rs2 = 1'b1;
                // funct7 0x20 only for sub
                legal = (funct3 != 3'b011) &&
                        ((funct7 == 7'b0000000) ||
                         (funct7 == 7'b0100000 && funct3 == 3'b000));
                if (funct7[5]) begin
                    alu_op = alu_sub;
                end
            end
            op_imm: begin
                // slli and srli need a clean upper field, srai is illegal here
                legal = (funct3 != 3'b011) &&
                        ((funct3[1:0] != 2'b01) || (funct7 == 7'b0000000));
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // x0 always reads zero
    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

    // result still in execute overrides the file
    assign op_a = fwd_a ? wb_data : rs1_val;

    always_comb begin
        if (!uses_rs2) begin
            op_b = instr_imm_i(fetch_instr);
        end else if (fwd_b) begin
            op_b = wb_data;
        end else begin
            op_b = rs2_val;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // bubble when nothing was fetched or the encoding is unsupported
    always_ff @(posedge clk) begin
        if (rst) begin
            dx.valid <= 1'b0;
        end else begin
            dx.valid <= fetch_valid & legal;
        end
    end

    always_ff @(posedge clk) begin
        dx.alu_op <= alu_op;
        dx.op_a   <= op_a;
        dx.op_b   <= op_b;
        dx.rd     <= instr_rd(fetch_instr);
    end

endmodule

//--- design/rv_execute.sv
/* execute stage: ALU, combinational write-back to decode,
   registered retire trace */
`timescale 1ns/100ps

module rv_execute (
    input  logic             clk,
    input  logic             rst,
    dx_if.execute            dx,
    output logic             wb_en,
    output rv_pkg::reg_idx_t wb_rd,
    output rv_pkg::word_t    wb_data,
    output logic             retire_valid,
    output rv_pkg::reg_idx_t retire_rd,
    output rv_pkg::word_t    retire_data
);
    import rv_pkg::*;

    word_t      result;
    logic [4:0] shamt;
    logic       less;

    assign shamt = dx.op_b[4:0];
    assign less  = $signed(dx.op_a) < $signed(dx.op_b);

    always_comb begin
        case (dx.alu_op)
            alu_add: result = dx.op_a + dx.op_b;
            alu_sub: result = dx.op_a - dx.op_b;
            alu_and: result = dx.op_a & dx.op_b;
            alu_or:  result = dx.op_a | dx.op_b;
            alu_xor: result = dx.op_a ^ dx.op_b;
            alu_sll: result = dx.op_a << shamt;
            alu_srl: result = dx.op_a >> shamt;
            alu_slt: result = {{(xlen - 1){1'b0}}, less};
            default: result = '0;
        endcase
    end

    // same-cycle result, forwarded by decode and written at the edge
    assign wb_en   = dx.valid;
    assign wb_rd   = dx.rd;
    assign wb_data = (dx.rd == '0) ? '0 : result;

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= wb_en;
        end
    end

    // trace payload mirrors write-back
    always_ff @(posedge clk) begin
        retire_rd   <= wb_rd;
        retire_data <= wb_data;
    end

endmodule

//--- design/rv_fetch.sv
/* fetch stage: program counter and instr_req/instr_gnt request, holds
   the request until granted and registers the granted word */
`timescale 1ns/100ps

module rv_fetch #(
    parameter rv_pkg::word_t boot_addr = '0
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          instr_gnt,
    input  rv_pkg::word_t instr_data,
    output logic          instr_req,
    output rv_pkg::word_t instr_addr,
    output logic          fetch_valid,
    output rv_pkg::word_t fetch_instr
);
    import rv_pkg::*;

    word_t pc;
    logic  req_q;
    logic  granted;

    // a request completes on every edge with req and gnt both high
    assign granted = req_q & instr_gnt;

    assign instr_req  = req_q;
    assign instr_addr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= boot_addr;
            req_q       <= 1'b0;
            fetch_valid <= 1'b0;
        end else begin
            // request continuously once out of reset
            req_q       <= 1'b1;
            fetch_valid <= granted;
            if (granted) begin
                pc <= pc + word_t'(4);
            end
        end
    end

    // instruction word, valid only with fetch_valid
    always_ff @(posedge clk) begin
        if (granted) begin
            fetch_instr <= instr_data;
        end
    end

endmodule

//--- design/rv_hazard.sv
/* hazard unit: source against execute destination compare,
   forwarding selects for both operands */
`timescale 1ns/100ps

module rv_hazard (
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  rv_pkg::reg_idx_t ex_rd,
    input  logic             ex_valid,
    input  logic             uses_rs2,
    output logic             fwd_a,
    output logic             fwd_b
);

    logic ex_writes;

    // x0 is never a real producer
    assign ex_writes = ex_valid && (ex_rd != 5'd0);

    assign fwd_a = ex_writes && (rs1 == ex_rd);

    // immediate forms carry imm bits in the rs2 field
    assign fwd_b = ex_writes && uses_rs2 && (rs2 == ex_rd);

endmodule

//--- design/rv_pkg.sv
/* shared RV32I types: word and register index, opcode and ALU enums,
   field extraction helpers for the instruction decoder */
package rv_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0] reg_idx_t;

    // only the two ALU major opcodes are executed
    typedef enum logic [6:0] {
        op_imm = 7'b0010011,
        op_reg = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_slt
    } alu_op_e;

    function automatic reg_idx_t instr_rd(word_t instr);
        return instr[11:7];
    endfunction

    function automatic reg_idx_t instr_rs1(word_t instr);
        return instr[19:15];
    endfunction

    function automatic reg_idx_t instr_rs2(word_t instr);
        return instr[24:20];
    endfunction

    function automatic logic [2:0] instr_funct3(word_t instr);
        return instr[14:12];
    endfunction

    function automatic logic [6:0] instr_funct7(word_t instr);
        return instr[31:25];
    endfunction

    // I-type immediate, sign extended
    function automatic word_t instr_imm_i(word_t instr);
        return {{(xlen - 12){instr[31]}}, instr[31:20]};
    endfunction

endpackage

//--- dv/imem_model.sv
/* instruction memory model: word array, registered grant gated by
   run and a stall input, read data valid with the grant */
`timescale 1ns/100ps

module imem_model #(
    parameter int depth = 1024
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          run,
    input  logic          stall,
    input  logic          req,
    input  rv_pkg::word_t addr,
    output logic          gnt,
    output rv_pkg::word_t data
);
    import rv_pkg::*;

    localparam int aw = $clog2(depth);

    word_t words [depth];

    // address is held until granted, so a plain read is enough
    assign data = words[addr[aw+1:2]];

    // grant follows the request by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            gnt <= 1'b0;
        end else begin
            gnt <= req & run & ~stall;
        end
    end

endmodule

//--- dv/rv_core_checker.sv
/* fetch bus and retire port assertions, bound into rv_core */
`timescale 1ns/100ps

module rv_core_checker (
    input logic          clk,
    input logic          rst,
    input logic          instr_req,
    input logic          instr_gnt,
    input rv_pkg::word_t instr_addr,
    input logic          retire_valid
);

    int assert_errs = 0;

    reset_idle: assert property (@(posedge clk) rst |=> !instr_req && !retire_valid)
        else begin
            $error("instr_req or retire_valid high right after reset");
            assert_errs++;
        end

    // request and address held until granted
    hold_until_gnt: assert property (@(posedge clk) disable iff (rst)
        instr_req && !instr_gnt |=> instr_req && $stable(instr_addr))
        else begin
            $error("instr_req dropped or instr_addr changed without a grant");
            assert_errs++;
        end

    next_addr: assert property (@(posedge clk) disable iff (rst)
        instr_req && instr_gnt |=> instr_addr == $past(instr_addr) + 32'd4)
        else begin
            $error("fetch address after a grant is not the previous address plus 4");
            assert_errs++;
        end

endmodule

bind rv_core rv_core_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .instr_req    (instr_req),
    .instr_gnt    (instr_gnt),
    .instr_addr   (instr_addr),
    .retire_valid (retire_valid)
);

//--- dv/rv_core_tb.sv
/* rv_core testbench: clock and reset, random ALU programs, register
   reference model, retire trace compare */
`timescale 1ns/100ps

module rv_core_tb;
    import rv_pkg::*;

    localparam int seed      = 1170;
    localparam int mem_depth = 1024;
    localparam int prog_len  = 300;
    localparam int timeout   = 4000;

    logic     clk = 1'b0;
    logic     rst;
    logic     run;
    logic     stall;
    logic     instr_gnt;
    logic     instr_req;
    word_t    instr_data;
    word_t    instr_addr;
    logic     retire_valid;
    reg_idx_t retire_rd;
    word_t    retire_data;

    int       value_errs = 0;
    int       other_errs = 0;
    word_t    prog [$];
    word_t    model_regs [32];
    reg_idx_t exp_rd [$];
    word_t    exp_data [$];
    reg_idx_t got_rd [$];
    word_t    got_data [$];

    always #2 clk = ~clk;

    rv_core #(.boot_addr('0)) dut (.*);

    imem_model #(.depth(mem_depth)) imem (
        .clk, .rst, .run, .stall,
        .req (instr_req), .addr (instr_addr), .gnt (instr_gnt), .data (instr_data)
    );

    task automatic check_rd(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            value_errs++;
            $display("FAIL %s: rd expected x%0d, actual x%0d", name, exp, act);
        end
    endtask

    task automatic check_data(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            value_errs++;
            $display("FAIL %s: data expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            value_errs++;
            $display("FAIL %s: retire count expected %0d, actual %0d", name, exp, act);
        end
    endtask

    function automatic word_t encode_reg(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                         logic [2:0] f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic word_t encode_imm(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                         reg_idx_t rd);
        return {imm, rs1, f3, rd, op_imm};
    endfunction

    // sources drawn from x0..x7 so that hazards are frequent
    function automatic word_t random_alu(reg_idx_t rd);
        logic [2:0] f3;
        logic [6:0] f7;
        reg_idx_t   rs1;
        f3  = 3'($urandom_range(6, 0));
        if (f3 >= 3'b011) begin
            f3 = f3 + 3'd1;
        end
        rs1 = reg_idx_t'($urandom_range(7, 0));
        f7  = (f3 == 3'b000 && $urandom_range(1, 0) == 1) ? 7'h20 : 7'h00;
        if ($urandom_range(1, 0) == 0) begin
            return encode_reg(f7, reg_idx_t'($urandom_range(7, 0)), rs1, f3, rd);
        end else if (f3 == 3'b001 || f3 == 3'b101) begin
            return encode_imm({7'h00, 5'($urandom())}, rs1, f3, rd);
        end
        return encode_imm(12'($urandom()), rs1, f3, rd);
    endfunction

    // load and branch opcodes
    function automatic word_t random_illegal();
        word_t w;
        w      = $urandom();
        w[6:0] = ($urandom_range(1, 0) == 1) ? 7'b0000011 : 7'b1100011;
        return w;
    endfunction

    task automatic add_prologue();
        for (int r = 1; r < 16; r++) begin
            prog.push_back(encode_imm(12'($urandom()), 5'd0, 3'b000, reg_idx_t'(r)));
        end
    endtask

    // RV32I rules for the supported subset, expectations in program order
    task automatic execute_model(input word_t instr);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        reg_idx_t   rd;
        word_t      a;
        word_t      b;
        word_t      res;
        logic       legal;
        opc = instr[6:0];
        f3  = instr[14:12];
        f7  = instr[31:25];
        rd  = instr[11:7];
        a   = model_regs[instr[19:15]];
        if (opc == op_reg) begin
            b     = model_regs[instr[24:20]];
            legal = (f7 == 7'h00 && f3 != 3'b011) || (f7 == 7'h20 && f3 == 3'b000);
        end else begin
            b     = {{20{instr[31]}}, instr[31:20]};
            legal = opc == op_imm && f3 != 3'b011 &&
                    !((f3 == 3'b001 || f3 == 3'b101) && f7 != 7'h00);
        end
        case (f3)
            3'b000:  res = (opc == op_reg && f7[5]) ? a - b : a + b;
            3'b001:  res = a << b[4:0];
            3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  res = a ^ b;
            3'b101:  res = a >> b[4:0];
            3'b110:  res = a | b;
            default: res = a & b;
        endcase
        if (legal) begin
            if (rd == 5'd0) begin
                res = '0;
            end
            model_regs[rd] = res;
            exp_rd.push_back(rd);
            exp_data.push_back(res);
        end
    endtask

    task automatic sample_retire(input string name);
        int k;
        k = got_rd.size();
        if (retire_valid) begin
            got_rd.push_back(retire_rd);
            got_data.push_back(retire_data);
            if (k < exp_rd.size()) begin
                check_rd($sformatf("%s[%0d]", name, k), exp_rd[k], retire_rd);
                check_data($sformatf("%s[%0d]", name, k), exp_data[k], retire_data);
            end else begin
                other_errs++;
                $display("%s: unexpected retire to x%0d after the last instruction",
                         name, retire_rd);
            end
        end
    endtask

    task automatic run_program(input string name, input int stall_pct);
        int cycles;
        exp_rd.delete();
        exp_data.delete();
        got_rd.delete();
        got_data.delete();
        model_regs = '{default: '0};
        foreach (prog[i]) begin
            execute_model(prog[i]);
        end
        rst   = 1'b1;
        run   = 1'b0;
        stall = 1'b0;
        // words behind the program hold an address-dependent opcode 0
        for (int i = 0; i < mem_depth; i++) begin
            imem.words[i] = (i < prog.size()) ? prog[i] : (word_t'(i) << 7);
        end
        repeat (8) @(negedge clk);
        rst    = 1'b0;
        run    = 1'b1;
        cycles = 0;
        while (got_rd.size() < exp_rd.size() && cycles < timeout) begin
            @(negedge clk);
            sample_retire(name);
            stall = ($urandom_range(99, 0) < stall_pct);
            cycles++;
        end
        if (got_rd.size() < exp_rd.size()) begin
            other_errs++;
            $display("%s: timed out after %0d cycles with %0d of %0d instructions retired",
                     name, cycles, got_rd.size(), exp_rd.size());
        end
        repeat (16) begin
            @(negedge clk);
            sample_retire(name);
        end
        check_count(name, exp_rd.size(), got_rd.size());
        run   = 1'b0;
        stall = 1'b0;
    endtask

    initial begin
        reg_idx_t base_rd [$];
        word_t    base_data [$];
        reg_idx_t d;
        int       n;
        rst   = 1'b1;
        run   = 1'b0;
        stall = 1'b0;
        void'($urandom(seed));

        n = $urandom_range(31, 8);
        prog.push_back(encode_imm(12'd1, 5'd0, 3'b000, 5'd1));
        repeat (n) prog.push_back(encode_reg(7'h00, 5'd1, 5'd1, 3'b000, 5'd1));
        run_program("doubler", 0);
        for (int k = 1; k <= n && k < got_data.size(); k++) begin
            check_data("doubler_pow2", word_t'(1) << k, got_data[k]);
        end

        prog.delete();
        add_prologue();
        repeat (prog_len) prog.push_back(random_alu(reg_idx_t'($urandom_range(7, 0))));
        run_program("random_alu", 0);
        base_rd   = got_rd;
        base_data = got_data;

        // same program, grants withheld at random
        run_program("grant_stalls", 30);
        check_count("grant_stalls_vs_base", base_rd.size(), got_rd.size());
        foreach (base_rd[i]) begin
            if (i < got_rd.size()) begin
                check_rd("grant_stalls_vs_base", base_rd[i], got_rd[i]);
                check_data("grant_stalls_vs_base", base_data[i], got_data[i]);
            end
        end

        // producer, unrelated write to x8..x15, consumer of the producer
        prog.delete();
        add_prologue();
        repeat (40) begin
            d = reg_idx_t'($urandom_range(7, 1));
            prog.push_back(random_alu(d));
            prog.push_back(encode_imm(12'($urandom()), 5'd0, 3'b000,
                                      reg_idx_t'($urandom_range(15, 8))));
            prog.push_back(encode_reg(7'h00, reg_idx_t'($urandom_range(7, 1)), d, 3'b000,
                                      reg_idx_t'($urandom_range(7, 1))));
        end
        run_program("two_apart", 0);

        // x0 write followed at once by an or that reads x0
        prog.delete();
        add_prologue();
        repeat (30) begin
            prog.push_back(random_alu(5'd0));
            prog.push_back(encode_reg(7'h00, reg_idx_t'($urandom_range(7, 1)), 5'd0, 3'b110,
                                      reg_idx_t'($urandom_range(7, 1))));
        end
        run_program("x0_rule", 0);

        prog.delete();
        add_prologue();
        repeat (100) begin
            if ($urandom_range(3, 0) == 0) begin
                prog.push_back(random_illegal());
            end else begin
                prog.push_back(random_alu(reg_idx_t'($urandom_range(7, 0))));
            end
        end
        run_program("illegal_words", 10);

        $display("errors: %0d value, %0d other, %0d assertion",
                 value_errs, other_errs, dut.u_checker.assert_errs);
        if (value_errs == 0 && other_errs == 0 && dut.u_checker.assert_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
